// ==== project.f ====
+incdir+hw
hw/i2c_bus_pkg.sv
hw/i2c_reg_pkg.sv
hw/i2c_io_buffer.sv
hw/i2c_slave_code_detect.sv
hw/i2c_frontend.sv
hw/i2c_slave_reg.sv
hw/i2c_reg_bank.sv
verification/tb_i2c_reg_bank.sv

// ==== Makefile ====
# Verilator build and run for the I2C register bank

VERILATOR  ?= verilator
TOP        := tb_i2c_reg_bank
RTL_TOP    := i2c_reg_bank
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep '\.sv$$' $(FILELIST)) hw/i2c_defs.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_i2c_reg_bank.sv ====
// Testbench for the I2C register bank
// A bit-level I2C master writes and reads the control and gain registers.
// Expected register values are kept in a small model updated from the
// protocol rules. Immediate and concurrent assertions do the checking.
// Run it as top module tb_i2c_reg_bank with the project file list.

`timescale 1ns/100ps

`include "i2c_defs.svh"

module tb_i2c_reg_bank;

	import i2c_reg_pkg::*;

	// clk cycles per quarter of an SCL bit
	localparam int QUARTER = 8;
	localparam int BIT_CYCLES = 4 * QUARTER;
	// Bit times per test; start, stop and the settle wait count as one bit each
	localparam int TOTAL_BITS = 1 + 30 + 21 + 60 + 51 + 49;
	// 25 percent margin on top
	localparam int MAX_CYCLES = TOTAL_BITS * BIT_CYCLES * 5 / 4;
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;
	// No slave answers here
	localparam logic [6:0] BAD_ADDR = 7'h50;

	logic clk;
	logic reset;
	logic scl;
	// Master side of the open-drain SDA
	logic sda_release;
	tri1 sda;
	ctrl_word_t ctrl_out;
	gain_word_t gain_out;

	// Expected register contents
	ctrl_word_t ctrl_model;
	gain_word_t gain_model;

	logic [31:0] lfsr_state;
	logic bus_idle;
	logic ack_bit;
	logic [7:0] b0;
	logic [7:0] b1;
	logic [7:0] b2;
	logic [7:0] rd0;
	logic [7:0] rd1;
	int cycle_count = 0;
	int check_count;
	int error_count;
	int errors_at_test_start;

	assign sda = sda_release ? 1'bz : 1'b0;

	i2c_reg_bank uut (
		.clk     (clk),
		.reset   (reset),
		.scl     (scl),
		.sda     (sda),
		.ctrl_out(ctrl_out),
		.gain_out(gain_out)
	);

	always #20 clk = ~clk;

	// Cycle limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not complete", cycle_count);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Nobody may pull SDA while the bus is idle
	assert property (@(posedge clk) disable iff (reset) bus_idle |-> sda)
		else begin
			$display("FAILED at %0t ns: sda expected 1 got %b on idle bus", $time, sda);
			error_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !$isunknown({ctrl_out, gain_out}))
		else begin
			$display("register outputs unknown at %0t ns", $time);
			error_count++;
		end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit, MSB taken first
	task automatic random_byte(output logic [7:0] value);
		for (int i = 0; i < 8; i++) begin
			value = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
			else begin
				$display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
				error_count++;
			end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s finished with %0d errors", num, name,
			error_count - errors_at_test_start);
		errors_at_test_start = error_count;
	endtask

	// Returns 2 ns after a rising clk edge
	task automatic wait_quarter();
		repeat (QUARTER) @(posedge clk);
		#2;
	endtask

	task automatic wait_bit();
		repeat (4) wait_quarter();
	endtask

	// Also serves as repeated start, entered with SCL low
	task automatic send_start();
		bus_idle = 1'b0;
		sda_release = 1'b1;
		wait_quarter();
		scl = 1'b1;
		wait_quarter();
		sda_release = 1'b0;
		wait_quarter();
		scl = 1'b0;
		wait_quarter();
	endtask

	task automatic send_stop();
		sda_release = 1'b0;
		wait_quarter();
		scl = 1'b1;
		wait_quarter();
		sda_release = 1'b1;
		wait_quarter();
		bus_idle = 1'b1;
	endtask

	// SDA set while SCL low, sampled in the middle of SCL high
	task automatic clock_bit(input logic value, output logic sampled);
		sda_release = value;
		wait_quarter();
		scl = 1'b1;
		wait_quarter();
		sampled = sda;
		wait_quarter();
		scl = 1'b0;
		wait_quarter();
	endtask

	// ack_seen is 0 when the slave acknowledged
	task automatic write_byte(input logic [7:0] data, output logic ack_seen);
		logic unused;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(data[i], unused);
		end
		clock_bit(1'b1, ack_seen);
	endtask

	task automatic read_byte(output logic [7:0] data, input logic nack);
		logic unused;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, data[i]);
		end
		clock_bit(nack, unused);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		scl = 1'b1;
		sda_release = 1'b1;
		bus_idle = 1'b1;
		lfsr_state = 32'h50c1;
		check_count = 0;
		error_count = 0;
		errors_at_test_start = 0;
		ctrl_model = `I2C_CTRL_RESET;
		gain_model = `I2C_GAIN_RESET;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		wait_bit();
		check_value("ctrl_out", ctrl_model, ctrl_out);
		check_value("gain_out", gain_model, gain_out);
		check_value("sda", 32'd1, sda);
		report_test(1, "reset state");

		// Two bytes fill the control register, first byte high
		random_byte(b0);
		random_byte(b1);
		send_start();
		write_byte({`I2C_CTRL_ADDR, 1'b0}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		write_byte(b0, ack_bit);
		check_value("data ack", 32'd0, ack_bit);
		write_byte(b1, ack_bit);
		check_value("data ack", 32'd0, ack_bit);
		send_stop();
		wait_bit();
		ctrl_model = {b0, b1};
		check_value("ctrl_out", ctrl_model, ctrl_out);
		check_value("gain_out", gain_model, gain_out);
		report_test(2, "full write");

		random_byte(b0);
		send_start();
		write_byte({BAD_ADDR, 1'b0}, ack_bit);
		check_value("address ack", 32'd1, ack_bit);
		write_byte(b0, ack_bit);
		send_stop();
		wait_bit();
		check_value("ctrl_out", ctrl_model, ctrl_out);
		check_value("gain_out", gain_model, gain_out);
		report_test(3, "wrong address");

		// Short write is dropped
		random_byte(b0);
		send_start();
		write_byte({`I2C_CTRL_ADDR, 1'b0}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		write_byte(b0, ack_bit);
		send_stop();
		wait_bit();
		check_value("ctrl_out", ctrl_model, ctrl_out);
		// Extra bytes past the width are dropped
		random_byte(b0);
		random_byte(b1);
		random_byte(b2);
		send_start();
		write_byte({`I2C_GAIN_ADDR, 1'b0}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		write_byte(b0, ack_bit);
		write_byte(b1, ack_bit);
		write_byte(b2, ack_bit);
		send_stop();
		wait_bit();
		gain_model = b0;
		check_value("gain_out", gain_model, gain_out);
		check_value("ctrl_out", ctrl_model, ctrl_out);
		report_test(4, "length rules");

		send_start();
		write_byte({`I2C_GAIN_ADDR, 1'b1}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		read_byte(rd0, 1'b1);
		send_stop();
		wait_bit();
		check_value("gain read data", gain_model, rd0);
		send_start();
		write_byte({`I2C_CTRL_ADDR, 1'b1}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		read_byte(rd0, 1'b0);
		read_byte(rd1, 1'b1);
		send_stop();
		wait_bit();
		check_value("ctrl read data", ctrl_model, {rd0, rd1});
		check_value("ctrl_out", ctrl_model, ctrl_out);
		check_value("gain_out", gain_model, gain_out);
		report_test(5, "read back");

		// Gain write is cut off by the repeated start, never committed
		random_byte(b0);
		random_byte(b1);
		random_byte(b2);
		send_start();
		write_byte({`I2C_GAIN_ADDR, 1'b0}, ack_bit);
		write_byte(b0, ack_bit);
		send_start();
		write_byte({`I2C_CTRL_ADDR, 1'b0}, ack_bit);
		check_value("address ack", 32'd0, ack_bit);
		write_byte(b1, ack_bit);
		write_byte(b2, ack_bit);
		send_stop();
		wait_bit();
		ctrl_model = {b1, b2};
		check_value("ctrl_out", ctrl_model, ctrl_out);
		check_value("gain_out", gain_model, gain_out);
		report_test(6, "repeated start");

		$display("tests 6, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== hw/i2c_reg_bank.sv ====
// Top level of the I2C register bank
// One shared frontend feeds a control register slave and a gain register
// slave. SDA is open-drain with an external pull-up.
// ctrl_out and gain_out always show the committed register values.

`timescale 1ns/100ps

`include "i2c_defs.svh"

module i2c_reg_bank (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    scl,
	inout  wire                     sda,
	output i2c_reg_pkg::ctrl_word_t ctrl_out,
	output i2c_reg_pkg::gain_word_t gain_out
);

	import i2c_bus_pkg::*;

	// Frontend to slaves
	logic       rx_stop;
	logic       rx_content;
	logic       content_strobe;
	bit_count_t bit_count;
	dev_addr_t  pkt_address;
	logic       pkt_read_wr;
	logic       pkt_addressed;

	// Slaves back to frontend
	logic ack;
	logic tx_content;
	logic ctrl_ack;
	logic gain_ack;
	logic ctrl_tx;
	logic gain_tx;

	// Unaddressed slaves give ack 0 and tx 1
	assign ack        = ctrl_ack | gain_ack;
	assign tx_content = ctrl_tx & gain_tx;

	i2c_frontend u_frontend (
		.clk           (clk),
		.reset         (reset),
		.scl           (scl),
		.sda           (sda),
		.tx_content    (tx_content),
		.ack           (ack),
		.rx_stop       (rx_stop),
		.rx_content    (rx_content),
		.content_strobe(content_strobe),
		.bit_count     (bit_count),
		.pkt_address   (pkt_address),
		.pkt_read_wr   (pkt_read_wr),
		.pkt_addressed (pkt_addressed)
	);

	i2c_slave_reg #(
		.DEV_ADDR   (`I2C_CTRL_ADDR),
		.WIDTH      (`I2C_CTRL_WIDTH),
		.RESET_VALUE(`I2C_CTRL_RESET)
	) u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.rx_stop       (rx_stop),
		.rx_content    (rx_content),
		.content_strobe(content_strobe),
		.bit_count     (bit_count),
		.pkt_address   (pkt_address),
		.pkt_read_wr   (pkt_read_wr),
		.pkt_addressed (pkt_addressed),
		.ack           (ctrl_ack),
		.tx_content    (ctrl_tx),
		.reg_out       (ctrl_out)
	);

	i2c_slave_reg #(
		.DEV_ADDR   (`I2C_GAIN_ADDR),
		.WIDTH      (`I2C_GAIN_WIDTH),
		.RESET_VALUE(`I2C_GAIN_RESET)
	) u_gain (
		.clk           (clk),
		.reset         (reset),
		.rx_stop       (rx_stop),
		.rx_content    (rx_content),
		.content_strobe(content_strobe),
		.bit_count     (bit_count),
		.pkt_address   (pkt_address),
		.pkt_read_wr   (pkt_read_wr),
		.pkt_addressed (pkt_addressed),
		.ack           (gain_ack),
		.tx_content    (gain_tx),
		.reg_out       (gain_out)
	);

endmodule

// ==== hw/i2c_slave_reg.sv ====
// Single-register I2C slave
// Claims one device address. A write shifts data into a shadow word and
// commits it at stop, but only when at least WIDTH bits came in.
// Extra bits are dropped. A read shifts reg_out out MSB first, then 1s.
// ack and tx_content are combined with the other slaves at the top level.

`timescale 1ns/100ps

module i2c_slave_reg #(
	parameter i2c_bus_pkg::dev_addr_t DEV_ADDR    = 7'h00,
	parameter int                     WIDTH       = 8,
	parameter logic [WIDTH-1:0]       RESET_VALUE = '0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rx_stop,
	input  logic                    rx_content,
	input  logic                    content_strobe,
	input  i2c_bus_pkg::bit_count_t bit_count,
	input  i2c_bus_pkg::dev_addr_t  pkt_address,
	input  logic                    pkt_read_wr,
	input  logic                    pkt_addressed,
	output logic                    ack,
	output logic                    tx_content,
	output logic [WIDTH-1:0]        reg_out
);

	import i2c_bus_pkg::*;

	// Address byte plus one full register
	localparam bit_count_t FULL_COUNT = bit_count_t'(WIDTH + 8);

	logic dev_addressed;
	logic write_active;
	logic read_active;

	// Incoming write data
	logic [WIDTH-1:0] shadow;
	// Outgoing read data
	logic [WIDTH-1:0] tx_shift;

	assign dev_addressed = pkt_addressed && (pkt_address == DEV_ADDR);
	assign write_active  = dev_addressed && !pkt_read_wr;
	assign read_active   = dev_addressed && pkt_read_wr;

	// Claim both directions
	assign ack = dev_addressed;

	// Idle level 1 keeps the wired-AND neutral
	assign tx_content = read_active ? tx_shift[WIDTH-1] : 1'b1;

	// Bits past the register width are not stored
	always_ff @(posedge clk) begin
		if (content_strobe && write_active && bit_count < FULL_COUNT) begin
			shadow <= {shadow[WIDTH-2:0], rx_content};
		end
	end

	// Follows reg_out until a read starts, then shifts with 1 fill
	always_ff @(posedge clk) begin
		if (!read_active) begin
			tx_shift <= reg_out;
		end else if (content_strobe) begin
			tx_shift <= {tx_shift[WIDTH-2:0], 1'b1};
		end
	end

	// Commit at stop, short writes are dropped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reg_out <= RESET_VALUE;
		end else if (rx_stop && write_active && bit_count >= FULL_COUNT) begin
			reg_out <= shadow;
		end
	end

	assert property (@(posedge clk) disable iff (reset) $changed(reg_out) |-> $past(rx_stop))
		else $error("reg_out changed without stop: addr=%h value=%h", DEV_ADDR, reg_out);

endmodule

// ==== hw/i2c_frontend.sv ====
// Packet decoder for I2C slaves
// After a start, shifts in the address byte and exposes pkt_address,
// pkt_read_wr and pkt_addressed to the register slaves.
// Later non-ACK bits go out on rx_content with a content_strobe pulse,
// and the slave answers with tx_content in the same cycle.
// ACK slots are handled here from the slaves' combined ack.

`timescale 1ns/100ps

module i2c_frontend (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   scl,
	inout  wire                    sda,
	input  logic                   tx_content,
	input  logic                   ack,
	output logic                   rx_stop,
	output logic                   rx_content,
	output logic                   content_strobe,
	output i2c_bus_pkg::bit_count_t bit_count,
	output i2c_bus_pkg::dev_addr_t pkt_address,
	output logic                   pkt_read_wr,
	output logic                   pkt_addressed
);

	import i2c_bus_pkg::*;

	// Last bit of the address byte
	localparam bit_count_t ADDR_LAST_BIT = 8'd7;

	frontend_state_t state;
	frontend_state_t state_next;

	logic rx_start;
	logic rx_data;
	logic strobe;
	logic tx_data;

	// High for the whole ninth bit of a byte
	logic ack_flag;
	// Address byte, R/W in bit 0
	logic [7:0] addr_shift;
	// ACK slot after a read data byte belongs to the master
	logic master_ack_slot;

	i2c_slave_code_detect u_code_detect (
		.clk     (clk),
		.reset   (reset),
		.scl     (scl),
		.sda     (sda),
		.rx_start(rx_start),
		.rx_stop (rx_stop),
		.rx_data (rx_data),
		.strobe  (strobe),
		.tx_data (tx_data)
	);

	assign pkt_address = addr_shift[7:1];
	assign pkt_read_wr = addr_shift[0];
	assign pkt_addressed = (state == DATA);

	// Bit counter skips ACK bits, flag marks them instead
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bit_count <= '0;
			ack_flag  <= 1'b0;
		end else if (rx_start) begin
			bit_count <= '0;
			ack_flag  <= 1'b0;
		end else if (strobe && state != IDLE) begin
			if (ack_flag) begin
				ack_flag  <= 1'b0;
				bit_count <= bit_count + 1'b1;
			end else if (bit_count[2:0] == 3'd7) begin
				ack_flag <= 1'b1;
			end else begin
				bit_count <= bit_count + 1'b1;
			end
		end
	end

	// Address bits arrive MSB first
	always_ff @(posedge clk) begin
		if (state == ADDRESS && strobe) begin
			addr_shift <= {addr_shift[6:0], rx_data};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				state_next = IDLE;
			end
			// Eighth bit completes the address byte
			ADDRESS: begin
				if (strobe && !ack_flag && bit_count == ADDR_LAST_BIT) begin
					state_next = DATA;
				end
			end
			// No slave claimed the address, drop the rest of the packet
			DATA: begin
				if (strobe && ack_flag && bit_count == ADDR_LAST_BIT && !ack) begin
					state_next = IGNORE;
				end
			end
			IGNORE: begin
				state_next = IGNORE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
		// Bus conditions override everything, start wins
		if (rx_stop) begin
			state_next = IDLE;
		end
		if (rx_start) begin
			state_next = ADDRESS;
		end
	end

	// Released so the master's ACK or NACK can be seen
	assign master_ack_slot = pkt_read_wr && (bit_count != ADDR_LAST_BIT);

	// ACK slot pulls low on ack, else the slave's data bit
	assign tx_data = ack_flag ? (master_ack_slot || !ack) : tx_content;

	assign content_strobe = pkt_addressed && strobe && !ack_flag;
	assign rx_content = rx_data;

	assert property (@(posedge clk) disable iff (reset)
		content_strobe |-> !ack_flag && bit_count > ADDR_LAST_BIT)
		else $error("content_strobe in ACK slot or address byte, bit_count=%0d", bit_count);

	assert property (@(posedge clk) disable iff (reset) rx_start |=> bit_count == '0)
		else $error("bit_count not cleared after start: %0d", bit_count);

endmodule

// ==== hw/i2c_slave_code_detect.sv ====
// Bit-level code detector for an I2C slave
// Turns the synchronized bus into one-cycle pulses for start, stop and
// each received bit (strobe, with the bit on rx_data).
// tx_data is latched onto SDA at every falling SCL.

`timescale 1ns/100ps

module i2c_slave_code_detect (
	input  logic clk,
	input  logic reset,
	input  logic scl,
	inout  wire  sda,
	output logic rx_start,
	output logic rx_stop,
	output logic rx_data,
	output logic strobe,
	input  logic tx_data
);

	// Synchronized bus
	logic int_scl;
	logic int_sda_in;
	logic int_sda_out;

	// Levels from the cycle before, for edge detection
	logic prev_scl;
	logic prev_sda;

	i2c_io_buffer u_io_buffer (
		.clk        (clk),
		.reset      (reset),
		.ext_scl    (scl),
		.ext_sda    (sda),
		.int_scl    (int_scl),
		.int_sda_in (int_sda_in),
		.int_sda_out(int_sda_out)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prev_scl <= 1'b1;
			prev_sda <= 1'b1;
		end else begin
			prev_scl <= int_scl;
			prev_sda <= int_sda_in;
		end
	end

	// Output bit only changes while SCL is low
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			int_sda_out <= 1'b1;
		end else if (prev_scl && !int_scl) begin
			int_sda_out <= tx_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_start <= 1'b0;
			rx_stop  <= 1'b0;
			rx_data  <= 1'b0;
			strobe   <= 1'b0;
		end else begin
			// SCL high on both samples, SDA falls
			rx_start <= int_scl && prev_scl && prev_sda && !int_sda_in;
			// SCL high on both samples, SDA rises
			rx_stop  <= int_scl && prev_scl && !prev_sda && int_sda_in;
			// Data is sampled on rising SCL
			strobe   <= int_scl && !prev_scl;
			if (int_scl && !prev_scl) begin
				rx_data <= int_sda_in;
			end
		end
	end

	// SDA cannot fall and rise in the same sample
	assert property (@(posedge clk) disable iff (reset) !(rx_start && rx_stop))
		else $error("rx_start and rx_stop both high");

endmodule

// ==== hw/i2c_io_buffer.sv ====
// Pin buffer for an I2C slave
// Synchronizes SCL and SDA into the clk domain and drives SDA open-drain.
// int_sda_out low pulls the pin down, high releases it to the pull-up.

`timescale 1ns/100ps

`include "i2c_defs.svh"

module i2c_io_buffer (
	input  logic clk,
	input  logic reset,
	input  logic ext_scl,
	inout  wire  ext_sda,
	output logic int_scl,
	output logic int_sda_in,
	input  logic int_sda_out
);

	// Synchronizer chains, bit 0 samples the pin
	logic [`I2C_SYNC_STAGES-1:0] scl_sync;
	logic [`I2C_SYNC_STAGES-1:0] sda_sync;

	// Only ever pull low or release
	assign ext_sda = int_sda_out ? 1'bz : 1'b0;

	// Idle bus level is high, so the chains reset to 1
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			scl_sync <= '1;
			sda_sync <= '1;
		end else begin
			scl_sync <= {scl_sync[`I2C_SYNC_STAGES-2:0], ext_scl};
			sda_sync <= {sda_sync[`I2C_SYNC_STAGES-2:0], ext_sda};
		end
	end

	assign int_scl    = scl_sync[`I2C_SYNC_STAGES-1];
	assign int_sda_in = sda_sync[`I2C_SYNC_STAGES-1];

	// Floating or contended pins would show up here
	assert property (@(posedge clk) disable iff (reset) !$isunknown({int_scl, int_sda_in}))
		else $error("sync lines unknown: scl=%b sda=%b", int_scl, int_sda_in);

endmodule

// ==== hw/i2c_reg_pkg.sv ====
// Types of the register bank contents
// Word types of the control and gain registers, sized from the defines.

`include "i2c_defs.svh"

package i2c_reg_pkg;

	// Control register word
	typedef logic [`I2C_CTRL_WIDTH-1:0] ctrl_word_t;

	// Gain register word
	typedef logic [`I2C_GAIN_WIDTH-1:0] gain_word_t;

endpackage

// ==== hw/i2c_bus_pkg.sv ====
// Types of the I2C wire protocol
// Shared by the frontend, the register slaves and the top level.
// Modules import it inside their body and use scoped names in ports.

package i2c_bus_pkg;

	// 7-bit device address from the address byte
	typedef logic [6:0] dev_addr_t;

	// Non-ACK bits since the last start, address bits included
	typedef logic [7:0] bit_count_t;

	// Frontend packet decoder states
	typedef enum logic [1:0] {
		IDLE,
		ADDRESS,
		DATA,
		IGNORE
	} frontend_state_t;

endpackage

// ==== hw/i2c_defs.svh ====
// Build-time constants for the I2C register bank
// Device addresses, register widths and reset values of the two slaves,
// plus the depth of the pin synchronizer.
// Include this file wherever one of these macros is used.

`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// 7-bit device addresses on the bus
`define I2C_CTRL_ADDR 7'h21
`define I2C_GAIN_ADDR 7'h22

// Register widths in bits
`define I2C_CTRL_WIDTH 16
`define I2C_GAIN_WIDTH 8

// Values held after reset
`define I2C_CTRL_RESET 16'h0001
`define I2C_GAIN_RESET 8'h80

// Flops between the pins and the detector
`define I2C_SYNC_STAGES 2

`endif
